//--- common/csi2_raw10_pkg.sv
package csi2_raw10_pkg;

  // payload word from the packet layer.
  localparam int WORD_W = 32;

  // five bytes carry four pixels.
  localparam int GROUP_W = 40;

  localparam int PIX_W = 10;

  localparam int PIX_PER_GROUP = 4;

  typedef logic [WORD_W-1:0] word_t;

  typedef logic [GROUP_W-1:0] group_t;

  typedef logic [PIX_W-1:0] pixel_t;

  // pixel 0 sits in the lowest bits.
  typedef pixel_t [PIX_PER_GROUP-1:0] pixel_quad_t;

endpackage

//--- rtl/axis_reg_slice.sv
module axis_reg_slice
  import csi2_raw10_pkg::*;
#(
  parameter type payload_t = word_t
)
(
  input  logic     clk_i,
  input  logic     srst_i,

  input  logic     s_valid_i,
  input  payload_t s_data_i,
  input  logic     s_last_i,
  output logic     s_ready_o,

  output logic     m_valid_o,
  output payload_t m_data_o,
  output logic     m_last_o,
  input  logic     m_ready_i
);

  payload_t skid_data;
  logic     skid_last;
  logic     skid_valid;
  logic     accept;
  logic     main_free;

  // ready comes straight from a flop.
  assign s_ready_o = !skid_valid;
  assign accept    = s_valid_i && s_ready_o;
  assign main_free = !m_valid_o || m_ready_i;

  always_ff @( posedge clk_i )
  begin
    if( srst_i )
    begin
      m_valid_o  <= 1'b0;
      skid_valid <= 1'b0;
    end
    else if( main_free )
    begin
      m_valid_o  <= skid_valid || accept;
      skid_valid <= 1'b0;
    end
    else if( accept )
      skid_valid <= 1'b1;
  end

  always_ff @( posedge clk_i )
  begin
    if( main_free )
    begin
      m_data_o <= skid_valid ? skid_data : s_data_i;
      m_last_o <= skid_valid ? skid_last : s_last_i;
    end
  end

  // main is stalled, park the incoming beat.
  always_ff @( posedge clk_i )
  begin
    if( accept && !main_free )
    begin
      skid_data <= s_data_i;
      skid_last <= s_last_i;
    end
  end

  full_no_accept: assert property
  (
    @( posedge clk_i ) disable iff ( srst_i )
    skid_valid && !m_ready_i |=> skid_valid && m_valid_o && $stable( skid_data )
  );

endmodule

//--- gearbox/csi2_raw10_gearbox.sv
module csi2_raw10_gearbox
  import csi2_raw10_pkg::*;
(
  input  logic   clk_i,
  input  logic   srst_i,

  input  logic   s_valid_i,
  input  word_t  s_data_i,
  input  logic   s_last_i,
  output logic   s_ready_o,

  output logic   m_valid_o,
  output group_t m_data_o,
  output logic   m_last_o,
  input  logic   m_ready_i,

  output logic   err_o
);

  typedef enum logic [2:0]
  {
    WORD1_S,
    WORD2_S,
    WORD3_S,
    WORD4_S,
    WORD5_S
  } state_t;

  state_t state;
  state_t next_state;

  word_t  word_q;
  group_t group_next;
  logic   accept;
  logic   short_line;

  // one idle cycle after an error so that pulses never merge.
  assign s_ready_o = ( !m_valid_o || m_ready_i ) && !err_o;
  assign accept    = s_valid_i && s_ready_o;

  // last is only legal on the fifth word of a run.
  assign short_line = accept && s_last_i && ( state != WORD5_S );

  always_comb
  begin
    next_state = state;
    if( accept )
    begin
      if( s_last_i || ( state == WORD5_S ) )
        next_state = WORD1_S;
      else
        next_state = state_t'( state + 3'd1 );
    end
  end

  always_ff @( posedge clk_i )
  begin
    if( srst_i )
      state <= WORD1_S;
    else
      state <= next_state;
  end

  always_ff @( posedge clk_i )
  begin
    if( accept )
      word_q <= s_data_i;
  end

  // held bytes first, then the low bytes of the new word.
  always_comb
  begin
    case( state )
      WORD2_S: group_next = { s_data_i[7:0],  word_q };
      WORD3_S: group_next = { s_data_i[15:0], word_q[31:8] };
      WORD4_S: group_next = { s_data_i[23:0], word_q[31:16] };
      WORD5_S: group_next = { s_data_i,       word_q[31:24] };
      default: group_next = '0;
    endcase
  end

  always_ff @( posedge clk_i )
  begin
    if( accept && ( state != WORD1_S ) )
    begin
      m_data_o <= group_next;
      m_last_o <= s_last_i && ( state == WORD5_S );
    end
  end

  always_ff @( posedge clk_i )
  begin
    if( srst_i )
      m_valid_o <= 1'b0;
    else if( accept && ( state != WORD1_S ) )
      m_valid_o <= 1'b1;
    else if( m_ready_i )
      m_valid_o <= 1'b0;
  end

  always_ff @( posedge clk_i )
  begin
    if( srst_i )
      err_o <= 1'b0;
    else
      err_o <= short_line;
  end

  hold_under_stall: assert property
  (
    @( posedge clk_i ) disable iff ( srst_i )
    m_valid_o && !m_ready_i |=> m_valid_o && $stable( m_data_o ) && $stable( m_last_o )
  );

  err_single_pulse: assert property
  (
    @( posedge clk_i ) disable iff ( srst_i )
    err_o |=> !err_o
  );

endmodule

//--- rtl/raw10_unpacker.sv
module raw10_unpacker
  import csi2_raw10_pkg::*;
(
  input  logic        clk_i,
  input  logic        srst_i,

  input  logic        s_valid_i,
  input  group_t      s_data_i,
  input  logic        s_last_i,
  output logic        s_ready_o,

  output logic        m_valid_o,
  output pixel_quad_t m_pixels_o,
  output logic        m_last_o,
  input  logic        m_ready_i
);

  pixel_quad_t pixels_next;
  logic        accept;

  assign s_ready_o = !m_valid_o || m_ready_i;
  assign accept    = s_valid_i && s_ready_o;

  // upper eight bits from bytes 0..3, low pairs from byte 4.
  always_comb
  begin
    for( int i = 0; i < PIX_PER_GROUP; i++ )
      pixels_next[i] = { s_data_i[8*i +: 8], s_data_i[32 + 2*i +: 2] };
  end

  always_ff @( posedge clk_i )
  begin
    if( accept )
    begin
      m_pixels_o <= pixels_next;
      m_last_o   <= s_last_i;
    end
  end

  always_ff @( posedge clk_i )
  begin
    if( srst_i )
      m_valid_o <= 1'b0;
    else if( accept )
      m_valid_o <= 1'b1;
    else if( m_ready_i )
      m_valid_o <= 1'b0;
  end

  out_stable: assert property
  (
    @( posedge clk_i ) disable iff ( srst_i )
    m_valid_o && !m_ready_i |=> m_valid_o && $stable( m_pixels_o ) && $stable( m_last_o )
  );

endmodule

//--- rtl/csi2_raw10_rx.sv
module csi2_raw10_rx
  import csi2_raw10_pkg::*;
(
  input  logic        clk_i,
  input  logic        srst_i,

  input  logic        s_valid_i,
  input  word_t       s_data_i,
  input  logic        s_last_i,
  output logic        s_ready_o,

  output logic        m_valid_o,
  output pixel_quad_t m_pixels_o,
  output logic        m_last_o,
  input  logic        m_ready_i,

  output logic        err_o
);

  logic        in_valid;
  word_t       in_data;
  logic        in_last;
  logic        in_ready;

  logic        grp_valid;
  group_t      grp_data;
  logic        grp_last;
  logic        grp_ready;

  logic        pix_valid;
  pixel_quad_t pix_data;
  logic        pix_last;
  logic        pix_ready;

  axis_reg_slice #(
    .payload_t ( word_t )
  ) in_slice (
    .clk_i     ( clk_i     ),
    .srst_i    ( srst_i    ),
    .s_valid_i ( s_valid_i ),
    .s_data_i  ( s_data_i  ),
    .s_last_i  ( s_last_i  ),
    .s_ready_o ( s_ready_o ),
    .m_valid_o ( in_valid  ),
    .m_data_o  ( in_data   ),
    .m_last_o  ( in_last   ),
    .m_ready_i ( in_ready  )
  );

  csi2_raw10_gearbox gearbox (
    .clk_i     ( clk_i     ),
    .srst_i    ( srst_i    ),
    .s_valid_i ( in_valid  ),
    .s_data_i  ( in_data   ),
    .s_last_i  ( in_last   ),
    .s_ready_o ( in_ready  ),
    .m_valid_o ( grp_valid ),
    .m_data_o  ( grp_data  ),
    .m_last_o  ( grp_last  ),
    .m_ready_i ( grp_ready ),
    .err_o     ( err_o     )
  );

  raw10_unpacker unpacker (
    .clk_i      ( clk_i     ),
    .srst_i     ( srst_i    ),
    .s_valid_i  ( grp_valid ),
    .s_data_i   ( grp_data  ),
    .s_last_i   ( grp_last  ),
    .s_ready_o  ( grp_ready ),
    .m_valid_o  ( pix_valid ),
    .m_pixels_o ( pix_data  ),
    .m_last_o   ( pix_last  ),
    .m_ready_i  ( pix_ready )
  );

  axis_reg_slice #(
    .payload_t ( pixel_quad_t )
  ) out_slice (
    .clk_i     ( clk_i      ),
    .srst_i    ( srst_i     ),
    .s_valid_i ( pix_valid  ),
    .s_data_i  ( pix_data   ),
    .s_last_i  ( pix_last   ),
    .s_ready_o ( pix_ready  ),
    .m_valid_o ( m_valid_o  ),
    .m_data_o  ( m_pixels_o ),
    .m_last_o  ( m_last_o   ),
    .m_ready_i ( m_ready_i  )
  );

endmodule

//--- bench/tb_csi2_raw10_rx.sv
module tb_csi2_raw10_rx
  import csi2_raw10_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NROWS = 10;

  // per row the line length in words, ready duty (0 always, 1 half, 2 quarter),
  // data mode (0 random, 1 incrementing, 2 all ones) and expected err_o pulses.
  localparam int ROW_LEN  [NROWS] = '{ 5, 10, 40, 40, 20, 7, 10, 15, 9, 5 };
  localparam int ROW_DUTY [NROWS] = '{ 0, 0, 0, 1, 2, 0, 1, 2, 1, 0 };
  localparam int ROW_MODE [NROWS] = '{ 1, 0, 0, 0, 1, 0, 2, 1, 0, 2 };
  localparam int ROW_ERRS [NROWS] = '{ 0, 0, 0, 0, 0, 1, 0, 0, 1, 0 };

  logic        clk_i;
  logic        srst_i;
  logic        s_valid_i;
  word_t       s_data_i;
  logic        s_last_i;
  logic        s_ready_o;
  logic        m_valid_o;
  pixel_quad_t m_pixels_o;
  logic        m_last_o;
  logic        m_ready_i;
  logic        err_o;

  integer      seed = 32'h1b79084a;
  int          duty;
  pixel_t      pix_count;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          err_total = 0;
  int          valid_total = 0;
  int          stall_total = 0;
  int          row_quads [NROWS];

  word_t       stim_word [$];
  logic        stim_last [$];
  pixel_quad_t exp_quad [$];
  logic        exp_last [$];
  pixel_quad_t rx_quad [$];
  logic        rx_last [$];

  csi2_raw10_rx DUT (
    .clk_i      ( clk_i      ),
    .srst_i     ( srst_i     ),
    .s_valid_i  ( s_valid_i  ),
    .s_data_i   ( s_data_i   ),
    .s_last_i   ( s_last_i   ),
    .s_ready_o  ( s_ready_o  ),
    .m_valid_o  ( m_valid_o  ),
    .m_pixels_o ( m_pixels_o ),
    .m_last_o   ( m_last_o   ),
    .m_ready_i  ( m_ready_i  ),
    .err_o      ( err_o      )
  );

  always #4 clk_i = ~clk_i;

  // ready pattern and output capture.
  always @( negedge clk_i )
  begin
    logic [31:0] rnd;
    rnd = $random( seed );
    m_ready_i = ( duty == 0 ) || ( duty == 1 && rnd[0] ) || ( duty == 2 && rnd[1:0] == 2'b00 );
    if( !srst_i )
    begin
      if( m_valid_o )
        valid_total++;
      if( err_o )
        err_total++;
      if( !s_ready_o )
        stall_total++;
      if( m_valid_o && m_ready_i )
      begin
        rx_quad.push_back( m_pixels_o );
        rx_last.push_back( m_last_o );
      end
    end
  end

  function automatic int watchdog_ns();
    int total;
    total = 0;
    for( int i = 0; i < NROWS; i++ )
      total += ROW_LEN[i];
    return total * 8 * 8 + 2000;
  endfunction

  task automatic check_quad( input string name, input pixel_quad_t exp, input pixel_quad_t act );
    if( exp !== act )
    begin
      fail_cnt++;
      $display( "Fail %0t %s: expected %h actual %h", $time, name, exp, act );
    end
    else
      pass_cnt++;
  endtask

  task automatic check_last( input string name, input logic exp, input logic act );
    if( exp !== act )
    begin
      fail_cnt++;
      $display( "Fail %0t %s: expected %b actual %b", $time, name, exp, act );
    end
    else
      pass_cnt++;
  endtask

  task automatic check_count( input string name, input int exp, input int act );
    if( exp != act )
    begin
      fail_cnt++;
      $display( "Fail %0t %s: expected %0d actual %0d", $time, name, exp, act );
    end
    else
      pass_cnt++;
  endtask

  // reference RAW10 packing of one row into words and expected quads.
  task automatic build_row( input int r );
    logic [7:0]  bytes [$];
    pixel_quad_t q;
    logic [31:0] rnd;
    int          nbytes;
    int          nquads;
    nbytes = 4 * ROW_LEN[r];
    nquads = nbytes / 5;
    row_quads[r] = nquads;
    for( int g = 0; g < ( nbytes + 4 ) / 5; g++ )
    begin
      for( int i = 0; i < PIX_PER_GROUP; i++ )
      begin
        if( ROW_MODE[r] == 0 )
        begin
          rnd = $random( seed );
          q[i] = rnd[PIX_W-1:0];
        end
        else if( ROW_MODE[r] == 1 )
        begin
          q[i] = pix_count;
          pix_count = pix_count + 10'd1;
        end
        else
          q[i] = '1;
      end
      for( int i = 0; i < PIX_PER_GROUP; i++ )
        bytes.push_back( q[i][9:2] );
      bytes.push_back( { q[3][1:0], q[2][1:0], q[1][1:0], q[0][1:0] } );
      if( g < nquads )
      begin
        exp_quad.push_back( q );
        exp_last.push_back( ( ROW_LEN[r] % 5 == 0 ) && ( g == nquads - 1 ) );
      end
    end
    for( int w = 0; w < ROW_LEN[r]; w++ )
    begin
      stim_word.push_back( { bytes[4*w+3], bytes[4*w+2], bytes[4*w+1], bytes[4*w] } );
      stim_last.push_back( w == ROW_LEN[r] - 1 );
    end
  endtask

  // s_ready_o is a flop output, so it is settled at the falling edge.
  task automatic send_words();
    while( stim_word.size() > 0 )
    begin
      s_valid_i = 1'b1;
      s_data_i  = stim_word.pop_front();
      s_last_i  = stim_last.pop_front();
      while( !s_ready_o )
        @( negedge clk_i );
      @( negedge clk_i );
    end
    s_valid_i = 1'b0;
    s_last_i  = 1'b0;
  endtask

  // an err_o pulse always comes before the last quad of its own line leaves.
  task automatic score_row( input int r );
    int fails_before;
    int err_start;
    fails_before = fail_cnt;
    err_start    = err_total;
    @( posedge clk_i );
    duty = ROW_DUTY[r];
    while( rx_quad.size() < row_quads[r] )
      @( negedge clk_i );
    for( int k = 0; k < row_quads[r]; k++ )
    begin
      check_quad( "m_pixels_o", exp_quad.pop_front(), rx_quad.pop_front() );
      check_last( "m_last_o", exp_last.pop_front(), rx_last.pop_front() );
    end
    check_count( "err_o pulses", ROW_ERRS[r], err_total - err_start );
    $display( "row %0d len %0d duty %0d mode %0d quads %0d: %s", r, ROW_LEN[r], ROW_DUTY[r],
              ROW_MODE[r], row_quads[r], ( fail_cnt == fails_before ) ? "ok" : "mismatch" );
  endtask

  initial
  begin
    clk_i     = 1'b0;
    srst_i    = 1'b1;
    s_valid_i = 1'b0;
    s_data_i  = '0;
    s_last_i  = 1'b0;
    m_ready_i = 1'b1;
    duty      = 0;
    pix_count = '0;
    for( int r = 0; r < NROWS; r++ )
      build_row( r );
    repeat( 2 ) @( posedge clk_i );
    @( negedge clk_i );
    srst_i = 1'b0;
    // quiet outputs before the first word.
    repeat( 6 ) @( negedge clk_i );
    check_count( "m_valid_o cycles after reset", 0, valid_total );
    check_count( "err_o cycles after reset", 0, err_total );
    // lines follow each other with no gap.
    fork
      send_words();
      begin
        for( int r = 0; r < NROWS; r++ )
          score_row( r );
      end
    join
    repeat( 4 ) @( negedge clk_i );
    check_count( "extra quads", 0, rx_quad.size() );
    if( stall_total == 0 )
    begin
      fail_cnt++;
      $display( "s_ready_o never fell, so back-pressure never reached the input" );
    end
    else
      pass_cnt++;
    $display( "checks passed %0d failed %0d", pass_cnt, fail_cnt );
    if( fail_cnt == 0 )
      $display( "Simulation PASSED" );
    else
      $display( "Simulation FAILED" );
    $finish;
  end

  initial
  begin
    #( watchdog_ns() );
    $display( "timeout: the DUT stopped moving data before the table was done" );
    $display( "Simulation FAILED" );
    $finish;
  end

endmodule

//--- csi2_raw10_rx.f
common/csi2_raw10_pkg.sv
rtl/axis_reg_slice.sv
gearbox/csi2_raw10_gearbox.sv
rtl/raw10_unpacker.sv
rtl/csi2_raw10_rx.sv
bench/tb_csi2_raw10_rx.sv

//--- Makefile
SRCS := $(shell cat csi2_raw10_rx.f)

.PHONY: all run clean

all: obj_dir/Vtb_csi2_raw10_rx

obj_dir/Vtb_csi2_raw10_rx: $(SRCS) csi2_raw10_rx.f
	verilator --binary --timing --assert -j 0 --top-module tb_csi2_raw10_rx -f csi2_raw10_rx.f

run: obj_dir/Vtb_csi2_raw10_rx
	obj_dir/Vtb_csi2_raw10_rx > sim.log 2>&1; cat sim.log
	@if grep -q "Simulation FAILED" sim.log; then exit 1; fi
	@grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
